// ==== design/system_consts.svh ====
`ifndef SYSTEM_CONSTS_SVH
`define SYSTEM_CONSTS_SVH

// ******************************
// Register map
// ******************************

`define REG_GPIO0_OUT   4'd0
`define REG_GPIO0_TRI   4'd1
`define REG_GPIO0_IN    4'd2
`define REG_GPIO1_OUT   4'd4
`define REG_GPIO1_TRI   4'd5
`define REG_GPIO1_IN    4'd6
// Enable in bit 0, pattern select in bit 1, solid colour in bits 31:16
`define REG_VIDEO_CTRL  4'd8
`define REG_ID          4'd9

// Fixed word returned by the ID register
`define SYSTEM_ID_WORD  32'h5a17_0c64

// Number of GPIO bits that reach board pins, the rest loop back
`define GPIO_PIN_COUNT  17

// ******************************
// Video timing, in clocks and lines
// ******************************

`define H_ACTIVE_LEN    16
`define H_FRONT_LEN     2
`define H_SYNC_LEN      4
`define H_BACK_LEN      3
`define V_ACTIVE_LEN    4
`define V_FRONT_LEN     1
`define V_SYNC_LEN      2
`define V_BACK_LEN      1

// Pixels per colour bar
`define BAR_WIDTH       2

// Bar colours as Y, Cb, Cr from white down to black
`define BAR_Y0  8'heb
`define BAR_CB0 8'h80
`define BAR_CR0 8'h80
`define BAR_Y1  8'hd2
`define BAR_CB1 8'h10
`define BAR_CR1 8'h92
`define BAR_Y2  8'haa
`define BAR_CB2 8'ha6
`define BAR_CR2 8'h10
`define BAR_Y3  8'h91
`define BAR_CB3 8'h36
`define BAR_CR3 8'h22
`define BAR_Y4  8'h6a
`define BAR_CB4 8'hca
`define BAR_CR4 8'hde
`define BAR_Y5  8'h51
`define BAR_CB5 8'h5a
`define BAR_CR5 8'hf0
`define BAR_Y6  8'h29
`define BAR_CB6 8'hf0
`define BAR_CR6 8'h6e
`define BAR_Y7  8'h10
`define BAR_CB7 8'h80
`define BAR_CR7 8'h80

`endif

// ==== design/system_pkg.sv ====
package system_pkg;

  // ******************************
  // Vector types
  // ******************************

  // Word address on the register port
  typedef logic [3:0] reg_addr_t;

  // Data word on the register port
  typedef logic [31:0] reg_data_t;

  // The full GPIO vector, pins in the low bits and loopback above them
  typedef logic [63:0] gpio_vec_t;

  // One HDMI sample with luma in the upper byte and Cb or Cr in the lower byte
  typedef logic [15:0] pixel_t;

  // Pixel position within a line
  typedef logic [7:0] h_count_t;

  // Line position within a frame
  typedef logic [7:0] v_count_t;

  // ******************************
  // Grouped signals
  // ******************************

  // GPIO drive words, a set tristate bit releases the matching pin
  typedef struct packed {
    gpio_vec_t out_word;
    gpio_vec_t tri_word;
  } gpio_ctrl_t;

  // Video control, pattern_sel low gives colour bars and high gives a solid colour
  typedef struct packed {
    logic   enable;
    logic   pattern_sel;
    pixel_t solid_color;
  } video_ctrl_t;

  // Registered timing from the generator to the pattern stage
  typedef struct packed {
    logic     hsync;
    logic     vsync;
    logic     de;
    h_count_t h_count;
    v_count_t v_count;
  } video_timing_t;

  // Horizontal phase of the timing generator
  typedef enum logic [1:0] {
    H_ACTIVE,
    H_FRONT,
    H_SYNC,
    H_BACK
  } timing_state_t;

endpackage

// ==== design/cpu_reg_if.sv ====
`timescale 1ns/100ps

`include "system_consts.svh"

module cpu_reg_if (
  input  logic                     sys_clk_i,
  input  logic                     rst_n_i,
  input  logic                     reg_wr_i,
  input  logic                     reg_rd_i,
  input  system_pkg::reg_addr_t    reg_addr_i,
  input  system_pkg::reg_data_t    reg_wdata_i,
  input  system_pkg::gpio_vec_t    gpio_in_i,
  output system_pkg::reg_data_t    reg_rdata_o,
  output logic                     reg_rvalid_o,
  output system_pkg::gpio_ctrl_t   gpio_ctrl_o,
  output system_pkg::video_ctrl_t  video_ctrl_o
);

  // Control registers
  system_pkg::gpio_ctrl_t  gpio_ctrl_q;
  system_pkg::video_ctrl_t video_ctrl_q;

  // Readback word selected by the current address
  system_pkg::reg_data_t   rd_word;

  // ******************************
  // Register writes
  // ******************************

  always_ff @(posedge sys_clk_i) begin
    if (!rst_n_i) begin
      gpio_ctrl_q.out_word <= '0;
      // All pins start as inputs
      gpio_ctrl_q.tri_word <= '1;
      video_ctrl_q         <= '0;
    end else if (reg_wr_i) begin
      case (reg_addr_i)
        `REG_GPIO0_OUT:  gpio_ctrl_q.out_word[31:0]  <= reg_wdata_i;
        `REG_GPIO0_TRI:  gpio_ctrl_q.tri_word[31:0]  <= reg_wdata_i;
        `REG_GPIO1_OUT:  gpio_ctrl_q.out_word[63:32] <= reg_wdata_i;
        `REG_GPIO1_TRI:  gpio_ctrl_q.tri_word[63:32] <= reg_wdata_i;
        `REG_VIDEO_CTRL: begin
          video_ctrl_q.enable      <= reg_wdata_i[0];
          video_ctrl_q.pattern_sel <= reg_wdata_i[1];
          video_ctrl_q.solid_color <= reg_wdata_i[31:16];
        end
        // IN and ID registers are read only, other addresses are unmapped
        default: ;
      endcase
    end
  end

  assign gpio_ctrl_o  = gpio_ctrl_q;
  assign video_ctrl_o = video_ctrl_q;

  // ******************************
  // Register reads
  // ******************************

  always_comb begin
    rd_word = '0;
    case (reg_addr_i)
      `REG_GPIO0_OUT:  rd_word = gpio_ctrl_q.out_word[31:0];
      `REG_GPIO0_TRI:  rd_word = gpio_ctrl_q.tri_word[31:0];
      `REG_GPIO0_IN:   rd_word = gpio_in_i[31:0];
      `REG_GPIO1_OUT:  rd_word = gpio_ctrl_q.out_word[63:32];
      `REG_GPIO1_TRI:  rd_word = gpio_ctrl_q.tri_word[63:32];
      `REG_GPIO1_IN:   rd_word = gpio_in_i[63:32];
      // Bits 15:2 are reserved and read as zero
      `REG_VIDEO_CTRL: rd_word = {video_ctrl_q.solid_color, 14'd0,
                                  video_ctrl_q.pattern_sel, video_ctrl_q.enable};
      `REG_ID:         rd_word = `SYSTEM_ID_WORD;
      default:         rd_word = '0;
    endcase
  end

  // The valid pulse marks the read word one cycle after the strobe
  always_ff @(posedge sys_clk_i) begin
    if (!rst_n_i) begin
      reg_rvalid_o <= 1'b0;
    end else begin
      reg_rvalid_o <= reg_rd_i;
    end
  end

  // Read data is only meaningful while reg_rvalid_o is high
  always_ff @(posedge sys_clk_i) begin
    if (reg_rd_i) begin
      reg_rdata_o <= rd_word;
    end
  end

endmodule

// ==== design/gpio_bank.sv ====
`timescale 1ns/100ps

`include "system_consts.svh"

module gpio_bank (
  input  logic                         sys_clk_i,
  input  logic                         rst_n_i,
  input  system_pkg::gpio_ctrl_t       gpio_ctrl_i,
  output system_pkg::gpio_vec_t        gpio_in_o,
  inout  wire [`GPIO_PIN_COUNT-1:0]    gpio_bd_io
);

  // Two synchronizer stages for the board pin values
  logic [`GPIO_PIN_COUNT-1:0] pin_meta;
  logic [`GPIO_PIN_COUNT-1:0] pin_sync;

  // ******************************
  // Board pin buffers
  // ******************************

  // A low tristate bit drives the pin from the output word
  // A high tristate bit leaves the pin to the board
  for (genvar i = 0; i < `GPIO_PIN_COUNT; i++) begin : g_pin_buf
    assign gpio_bd_io[i] = gpio_ctrl_i.tri_word[i] ? 1'bz : gpio_ctrl_i.out_word[i];
  end

  // ******************************
  // Input synchronizer
  // ******************************

  // Pins can change at any time relative to sys_clk_i
  // The second stage is the first one safe to use
  always_ff @(posedge sys_clk_i) begin
    if (!rst_n_i) begin
      pin_meta <= '0;
      pin_sync <= '0;
    end else begin
      pin_meta <= gpio_bd_io;
      pin_sync <= pin_meta;
    end
  end

  // ******************************
  // Input vector
  // ******************************

  // Bits without a board pin see their own output value with no delay
  // Pin bits read back whatever is on the pin, driven by us or not
  assign gpio_in_o = {gpio_ctrl_i.out_word[63:`GPIO_PIN_COUNT], pin_sync};

endmodule

// ==== design/hdmi_timing_gen.sv ====
`timescale 1ns/100ps

`include "system_consts.svh"

module hdmi_timing_gen (
  input  logic                       sys_clk_i,
  input  logic                       rst_n_i,
  input  logic                       enable_i,
  output system_pkg::video_timing_t  timing_o
);

  // Last count of each horizontal phase
  localparam system_pkg::h_count_t H_ACTIVE_LAST = system_pkg::h_count_t'(`H_ACTIVE_LEN - 1);
  localparam system_pkg::h_count_t H_FRONT_LAST  = system_pkg::h_count_t'(`H_FRONT_LEN - 1);
  localparam system_pkg::h_count_t H_SYNC_LAST   = system_pkg::h_count_t'(`H_SYNC_LEN - 1);
  localparam system_pkg::h_count_t H_BACK_LAST   = system_pkg::h_count_t'(`H_BACK_LEN - 1);

  // Vertical phase boundaries as line numbers
  localparam system_pkg::v_count_t V_ACTIVE_END = system_pkg::v_count_t'(`V_ACTIVE_LEN);
  localparam system_pkg::v_count_t V_SYNC_START =
    system_pkg::v_count_t'(`V_ACTIVE_LEN + `V_FRONT_LEN);
  localparam system_pkg::v_count_t V_SYNC_END   =
    system_pkg::v_count_t'(`V_ACTIVE_LEN + `V_FRONT_LEN + `V_SYNC_LEN);
  localparam system_pkg::v_count_t V_LAST_LINE  =
    system_pkg::v_count_t'(`V_ACTIVE_LEN + `V_FRONT_LEN + `V_SYNC_LEN + `V_BACK_LEN - 1);

  // Position of the pixel that goes out at the next edge
  system_pkg::timing_state_t h_state;
  system_pkg::timing_state_t h_state_nxt;
  system_pkg::h_count_t      phase_cnt;
  system_pkg::v_count_t      line_cnt;

  logic phase_done;
  logic line_active;
  logic line_vsync;

  // ******************************
  // Phase decode
  // ******************************

  always_comb begin
    phase_done  = 1'b0;
    h_state_nxt = h_state;
    case (h_state)
      system_pkg::H_ACTIVE: begin
        phase_done  = (phase_cnt == H_ACTIVE_LAST);
        h_state_nxt = system_pkg::H_FRONT;
      end
      system_pkg::H_FRONT: begin
        phase_done  = (phase_cnt == H_FRONT_LAST);
        h_state_nxt = system_pkg::H_SYNC;
      end
      system_pkg::H_SYNC: begin
        phase_done  = (phase_cnt == H_SYNC_LAST);
        h_state_nxt = system_pkg::H_BACK;
      end
      default: begin
        phase_done  = (phase_cnt == H_BACK_LAST);
        h_state_nxt = system_pkg::H_ACTIVE;
      end
    endcase
  end

  // Vertical phase follows from the line number alone
  assign line_active = (line_cnt < V_ACTIVE_END);
  assign line_vsync  = (line_cnt >= V_SYNC_START) && (line_cnt < V_SYNC_END);

  // ******************************
  // Counters and registered timing
  // ******************************

  // Disabled, the generator parks on the first active pixel so that
  // it appears on the cycle after enable rises
  always_ff @(posedge sys_clk_i) begin
    if (!rst_n_i || !enable_i) begin
      h_state   <= system_pkg::H_ACTIVE;
      phase_cnt <= '0;
      line_cnt  <= '0;
      timing_o  <= '0;
    end else begin
      timing_o.hsync   <= (h_state == system_pkg::H_SYNC);
      timing_o.vsync   <= line_vsync;
      timing_o.de      <= (h_state == system_pkg::H_ACTIVE) && line_active;
      timing_o.h_count <= (h_state == system_pkg::H_ACTIVE) ? phase_cnt : '0;
      timing_o.v_count <= line_active ? line_cnt : '0;
      if (phase_done) begin
        phase_cnt <= '0;
        h_state   <= h_state_nxt;
        // Back porch is the end of the line
        if (h_state == system_pkg::H_BACK) begin
          line_cnt <= (line_cnt == V_LAST_LINE) ? '0 : line_cnt + 1'b1;
        end
      end else begin
        phase_cnt <= phase_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== design/hdmi_pattern_out.sv ====
`timescale 1ns/100ps

`include "system_consts.svh"

module hdmi_pattern_out (
  input  logic                       sys_clk_i,
  input  logic                       rst_n_i,
  input  system_pkg::video_timing_t  timing_i,
  input  logic                       pattern_sel_i,
  input  system_pkg::pixel_t         solid_color_i,
  output logic                       hdmi_hsync_o,
  output logic                       hdmi_vsync_o,
  output logic                       hdmi_data_e_o,
  output system_pkg::pixel_t         hdmi_data_o
);

  system_pkg::h_count_t bar_pos;
  logic [2:0]           bar_idx;
  // Bar colour as Y, Cb, Cr
  logic [23:0]          bar_ycc;
  logic [7:0]           bar_chroma;
  system_pkg::pixel_t   bar_pixel;

  // ******************************
  // Colour bar lookup
  // ******************************

  assign bar_pos = timing_i.h_count / system_pkg::h_count_t'(`BAR_WIDTH);
  assign bar_idx = bar_pos[2:0];

  always_comb begin
    case (bar_idx)
      3'd0:    bar_ycc = {`BAR_Y0, `BAR_CB0, `BAR_CR0};
      3'd1:    bar_ycc = {`BAR_Y1, `BAR_CB1, `BAR_CR1};
      3'd2:    bar_ycc = {`BAR_Y2, `BAR_CB2, `BAR_CR2};
      3'd3:    bar_ycc = {`BAR_Y3, `BAR_CB3, `BAR_CR3};
      3'd4:    bar_ycc = {`BAR_Y4, `BAR_CB4, `BAR_CR4};
      3'd5:    bar_ycc = {`BAR_Y5, `BAR_CB5, `BAR_CR5};
      3'd6:    bar_ycc = {`BAR_Y6, `BAR_CB6, `BAR_CR6};
      default: bar_ycc = {`BAR_Y7, `BAR_CB7, `BAR_CR7};
    endcase
  end

  // 4:2:2 packing puts Cb on even pixels and Cr on odd pixels
  assign bar_chroma = timing_i.h_count[0] ? bar_ycc[7:0] : bar_ycc[15:8];
  assign bar_pixel  = {bar_ycc[23:16], bar_chroma};

  // ******************************
  // Output register
  // ******************************

  // One stage behind the timing generator, sync and data stay aligned
  always_ff @(posedge sys_clk_i) begin
    if (!rst_n_i) begin
      hdmi_hsync_o  <= 1'b0;
      hdmi_vsync_o  <= 1'b0;
      hdmi_data_e_o <= 1'b0;
      hdmi_data_o   <= '0;
    end else begin
      hdmi_hsync_o  <= timing_i.hsync;
      hdmi_vsync_o  <= timing_i.vsync;
      hdmi_data_e_o <= timing_i.de;
      // Blanking carries zero data
      if (!timing_i.de) begin
        hdmi_data_o <= '0;
      end else if (pattern_sel_i) begin
        hdmi_data_o <= solid_color_i;
      end else begin
        hdmi_data_o <= bar_pixel;
      end
    end
  end

endmodule

// ==== design/system_top.sv ====
`timescale 1ns/100ps

`include "system_consts.svh"

module system_top (
  input  logic                       sys_clk_i,
  input  logic                       rst_n_i,

  // Register port
  input  logic                       reg_wr_i,
  input  logic                       reg_rd_i,
  input  system_pkg::reg_addr_t      reg_addr_i,
  input  system_pkg::reg_data_t      reg_wdata_i,
  output system_pkg::reg_data_t      reg_rdata_o,
  output logic                       reg_rvalid_o,

  output logic                       fan_pwm_o,

  inout  wire [`GPIO_PIN_COUNT-1:0]  gpio_bd_io,

  // 16-bit HDMI output
  output logic                       hdmi_hsync_o,
  output logic                       hdmi_vsync_o,
  output logic                       hdmi_data_e_o,
  output system_pkg::pixel_t         hdmi_data_o
);

  system_pkg::gpio_ctrl_t    gpio_ctrl;
  system_pkg::gpio_vec_t     gpio_in;
  system_pkg::video_ctrl_t   video_ctrl;
  system_pkg::video_timing_t video_timing;

  // Fan runs at full speed
  assign fan_pwm_o = 1'b1;

  // ******************************
  // Register access
  // ******************************

  cpu_reg_if i_cpu_reg_if (
    .sys_clk_i    (sys_clk_i),
    .rst_n_i      (rst_n_i),
    .reg_wr_i     (reg_wr_i),
    .reg_rd_i     (reg_rd_i),
    .reg_addr_i   (reg_addr_i),
    .reg_wdata_i  (reg_wdata_i),
    .gpio_in_i    (gpio_in),
    .reg_rdata_o  (reg_rdata_o),
    .reg_rvalid_o (reg_rvalid_o),
    .gpio_ctrl_o  (gpio_ctrl),
    .video_ctrl_o (video_ctrl));

  gpio_bank i_gpio_bank (
    .sys_clk_i   (sys_clk_i),
    .rst_n_i     (rst_n_i),
    .gpio_ctrl_i (gpio_ctrl),
    .gpio_in_o   (gpio_in),
    .gpio_bd_io  (gpio_bd_io));

  // ******************************
  // HDMI path
  // ******************************

  hdmi_timing_gen i_hdmi_timing_gen (
    .sys_clk_i (sys_clk_i),
    .rst_n_i   (rst_n_i),
    .enable_i  (video_ctrl.enable),
    .timing_o  (video_timing));

  hdmi_pattern_out i_hdmi_pattern_out (
    .sys_clk_i     (sys_clk_i),
    .rst_n_i       (rst_n_i),
    .timing_i      (video_timing),
    .pattern_sel_i (video_ctrl.pattern_sel),
    .solid_color_i (video_ctrl.solid_color),
    .hdmi_hsync_o  (hdmi_hsync_o),
    .hdmi_vsync_o  (hdmi_vsync_o),
    .hdmi_data_e_o (hdmi_data_e_o),
    .hdmi_data_o   (hdmi_data_o));

endmodule

// ==== verification/system_top_sva.sv ====
`timescale 1ns/100ps

module system_top_sva (
  input logic               sys_clk_i,
  input logic               rst_n_i,
  input logic               hdmi_hsync_i,
  input logic               hdmi_vsync_i,
  input logic               hdmi_data_e_i,
  input system_pkg::pixel_t hdmi_data_i,
  input logic               reg_rd_i,
  input logic               reg_rvalid_i
);

  // ******************************
  // HDMI output rules
  // ******************************

  // Active video never overlaps a sync pulse
  de_outside_sync: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
    !(hdmi_data_e_i && (hdmi_hsync_i || hdmi_vsync_i)))
    else $error("Data enable high during a sync pulse");

  // Blanking carries zero data
  data_zero_in_blank: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
    !hdmi_data_e_i |-> hdmi_data_i == 16'h0000)
    else $error("Non-zero HDMI data while data enable is low");

  // ******************************
  // Register read timing
  // ******************************

  rvalid_after_read: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
    reg_rd_i |=> reg_rvalid_i)
    else $error("Read strobe not followed by a valid pulse");

  rvalid_only_after_read: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
    reg_rvalid_i |-> $past(reg_rd_i))
    else $error("Valid pulse without a read strobe one cycle earlier");

endmodule

// The pattern stage has no register port, so those inputs are tied idle
bind hdmi_pattern_out system_top_sva i_pattern_sva (
  .sys_clk_i     (sys_clk_i),
  .rst_n_i       (rst_n_i),
  .hdmi_hsync_i  (hdmi_hsync_o),
  .hdmi_vsync_i  (hdmi_vsync_o),
  .hdmi_data_e_i (hdmi_data_e_o),
  .hdmi_data_i   (hdmi_data_o),
  .reg_rd_i      (1'b0),
  .reg_rvalid_i  (1'b0));

bind cpu_reg_if system_top_sva i_reg_sva (
  .sys_clk_i     (sys_clk_i),
  .rst_n_i       (rst_n_i),
  .hdmi_hsync_i  (1'b0),
  .hdmi_vsync_i  (1'b0),
  .hdmi_data_e_i (1'b0),
  .hdmi_data_i   (16'h0000),
  .reg_rd_i      (reg_rd_i),
  .reg_rvalid_i  (reg_rvalid_o));

// ==== verification/system_top_tb.sv ====
`timescale 1ns/100ps

`include "system_consts.svh"

module system_top_tb;

  // ******************************
  // Timing of the run
  // ******************************

  localparam int LINE_CYCLES  = `H_ACTIVE_LEN + `H_FRONT_LEN + `H_SYNC_LEN + `H_BACK_LEN;
  localparam int FRAME_CYCLES =
    LINE_CYCLES * (`V_ACTIVE_LEN + `V_FRONT_LEN + `V_SYNC_LEN + `V_BACK_LEN);
  // Video tests wait for and scan about 8 frames and register traffic adds the rest
  localparam int TIMEOUT_CYCLES = 8 * FRAME_CYCLES + 1400;

  logic                  sys_clk;
  logic                  rst_n;
  logic                  reg_wr;
  logic                  reg_rd;
  system_pkg::reg_addr_t reg_addr;
  system_pkg::reg_data_t reg_wdata;
  system_pkg::reg_data_t reg_rdata;
  logic                  reg_rvalid;
  logic                  fan_pwm;
  logic                  hdmi_hsync;
  logic                  hdmi_vsync;
  logic                  hdmi_data_e;
  system_pkg::pixel_t    hdmi_data;

  // The testbench drives the board side of the GPIO pins only while enabled
  wire  [`GPIO_PIN_COUNT-1:0] gpio_bd;
  logic                       pin_drive_en;
  logic [`GPIO_PIN_COUNT-1:0] pin_drive_val;

  int error_count;
  int pass_count;
  int fail_count;
  int cycle_count;

  assign gpio_bd = pin_drive_en ? pin_drive_val : {`GPIO_PIN_COUNT{1'bz}};

  system_top i_system_top (
    .sys_clk_i     (sys_clk),
    .rst_n_i       (rst_n),
    .reg_wr_i      (reg_wr),
    .reg_rd_i      (reg_rd),
    .reg_addr_i    (reg_addr),
    .reg_wdata_i   (reg_wdata),
    .reg_rdata_o   (reg_rdata),
    .reg_rvalid_o  (reg_rvalid),
    .fan_pwm_o     (fan_pwm),
    .gpio_bd_io    (gpio_bd),
    .hdmi_hsync_o  (hdmi_hsync),
    .hdmi_vsync_o  (hdmi_vsync),
    .hdmi_data_e_o (hdmi_data_e),
    .hdmi_data_o   (hdmi_data));

  always #2 sys_clk = ~sys_clk;

  // Ends a run that got stuck somewhere
  always @(posedge sys_clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("test failed");
      $finish;
    end
  end

  // ******************************
  // Helpers
  // ******************************

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string msg);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s, got %0h, expected %0h", $time, msg, actual, expected);
      error_count = error_count + 1;
    end
  endtask

  // All register tasks start and end 1 ns after a rising edge with strobes low
  task automatic reg_write(input system_pkg::reg_addr_t addr, input system_pkg::reg_data_t data);
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(posedge sys_clk);
    #1;
    reg_wr = 1'b0;
  endtask

  // Valid and data belong to the cycle right after the one that carried the strobe
  task automatic reg_read(input system_pkg::reg_addr_t addr, output system_pkg::reg_data_t data);
    reg_rd   = 1'b1;
    reg_addr = addr;
    @(posedge sys_clk);
    #1;
    reg_rd = 1'b0;
    if (!reg_rvalid) begin
      $display("Read of address %0d at %0t ns got no valid pulse one cycle after the strobe",
               addr, $time);
      error_count = error_count + 1;
    end
    data = reg_rdata;
  endtask

  task automatic wait_vsync_rise(output bit seen);
    int   waited;
    logic prev_vs;
    seen    = 1'b0;
    waited  = 0;
    prev_vs = hdmi_vsync;
    while (!seen && waited < 2 * FRAME_CYCLES) begin
      @(posedge sys_clk);
      #1;
      waited = waited + 1;
      seen   = hdmi_vsync && !prev_vs;
      prev_vs = hdmi_vsync;
    end
    if (!seen) begin
      $display("No vsync rising edge seen within %0d cycles at %0t ns", waited, $time);
      error_count = error_count + 1;
    end
  endtask

  // Expected 4:2:2 sample of the colour bars at a pixel position
  function automatic system_pkg::pixel_t bar_sample(input int pix);
    logic [23:0] ycc;
    case (pix / `BAR_WIDTH)
      0:       ycc = {`BAR_Y0, `BAR_CB0, `BAR_CR0};
      1:       ycc = {`BAR_Y1, `BAR_CB1, `BAR_CR1};
      2:       ycc = {`BAR_Y2, `BAR_CB2, `BAR_CR2};
      3:       ycc = {`BAR_Y3, `BAR_CB3, `BAR_CR3};
      4:       ycc = {`BAR_Y4, `BAR_CB4, `BAR_CR4};
      5:       ycc = {`BAR_Y5, `BAR_CB5, `BAR_CR5};
      6:       ycc = {`BAR_Y6, `BAR_CB6, `BAR_CR6};
      default: ycc = {`BAR_Y7, `BAR_CB7, `BAR_CR7};
    endcase
    // Even pixels carry Cb and odd pixels carry Cr
    return (pix % 2 == 0) ? {ycc[23:16], ycc[15:8]} : {ycc[23:16], ycc[7:0]};
  endfunction

  task automatic record_result(input string name, input int start_errors);
    int errors;
    errors = error_count - start_errors;
    if (errors == 0) begin
      pass_count = pass_count + 1;
    end else begin
      fail_count = fail_count + 1;
    end
    $display("[%0t ns] %s finished with %0d errors", $time, name, errors);
  endtask

  // ******************************
  // Directed tests
  // ******************************

  task automatic reset_and_id();
    int                    start_errors;
    system_pkg::reg_data_t wdata;
    system_pkg::reg_data_t rdata;
    system_pkg::reg_addr_t rw_addrs [4];
    start_errors = error_count;
    check_value(64'({hdmi_hsync, hdmi_vsync, hdmi_data_e}), 64'd0, "HDMI flags after reset");
    check_value(64'(hdmi_data), 64'd0, "HDMI data after reset");
    check_value(64'(fan_pwm), 64'd1, "Fan output level");
    check_value(64'(reg_rvalid), 64'd0, "Read valid after reset");
    reg_read(`REG_GPIO0_TRI, rdata);
    check_value(64'(rdata), 64'hffff_ffff, "GPIO0 tristate after reset");
    reg_read(`REG_GPIO1_OUT, rdata);
    check_value(64'(rdata), 64'd0, "GPIO1 output after reset");
    reg_read(`REG_ID, rdata);
    check_value(64'(rdata), 64'(`SYSTEM_ID_WORD), "ID word");
    // The ID register is read only
    reg_write(`REG_ID, $urandom());
    reg_read(`REG_ID, rdata);
    check_value(64'(rdata), 64'(`SYSTEM_ID_WORD), "ID word after a write");
    rw_addrs = '{`REG_GPIO0_OUT, `REG_GPIO0_TRI, `REG_GPIO1_OUT, `REG_GPIO1_TRI};
    foreach (rw_addrs[i]) begin
      wdata = $urandom();
      reg_write(rw_addrs[i], wdata);
      reg_read(rw_addrs[i], rdata);
      check_value(64'(rdata), 64'(wdata), $sformatf("Readback of address %0d", rw_addrs[i]));
    end
    // Enable stays low here and reserved bits 15:2 read as zero
    wdata = $urandom() & 32'hffff_fffe;
    reg_write(`REG_VIDEO_CTRL, wdata);
    reg_read(`REG_VIDEO_CTRL, rdata);
    check_value(64'(rdata), 64'(wdata & 32'hffff_0003), "Video control readback");
    reg_write(`REG_VIDEO_CTRL, 32'd0);
    reg_write(`REG_GPIO0_TRI, 32'hffff_ffff);
    reg_write(`REG_GPIO1_TRI, 32'hffff_ffff);
    for (int a = 0; a < 16; a++) begin
      if (a == 3 || a == 7 || a >= 10) begin
        reg_read(system_pkg::reg_addr_t'(a), rdata);
        check_value(64'(rdata), 64'd0, $sformatf("Unmapped address %0d", a));
      end
    end
    record_result("reset_and_id", start_errors);
  endtask

  task automatic gpio_pins();
    int                    start_errors;
    system_pkg::reg_data_t out_word;
    system_pkg::reg_data_t rnd;
    system_pkg::reg_data_t rdata;
    start_errors = error_count;
    out_word = $urandom();
    reg_write(`REG_GPIO0_OUT, out_word);
    reg_write(`REG_GPIO0_TRI, 32'd0);
    check_value(64'(gpio_bd), 64'(out_word[`GPIO_PIN_COUNT-1:0]), "Pins driven by GPIO0_OUT");
    // Driven pins come back through the synchronizer too
    repeat (2) @(posedge sys_clk);
    #1;
    reg_read(`REG_GPIO0_IN, rdata);
    check_value(64'(rdata[`GPIO_PIN_COUNT-1:0]), 64'(out_word[`GPIO_PIN_COUNT-1:0]),
                "GPIO0_IN of driven pins");
    reg_write(`REG_GPIO0_TRI, 32'hffff_ffff);
    for (int n = 0; n < 4; n++) begin
      rnd           = $urandom();
      pin_drive_val = rnd[`GPIO_PIN_COUNT-1:0];
      pin_drive_en  = 1'b1;
      repeat (3) @(posedge sys_clk);
      #1;
      reg_read(`REG_GPIO0_IN, rdata);
      check_value(64'(rdata[`GPIO_PIN_COUNT-1:0]), 64'(pin_drive_val), "GPIO0_IN of board pins");
    end
    pin_drive_en = 1'b0;
    record_result("gpio_pins", start_errors);
  endtask

  task automatic gpio_loopback();
    int                    start_errors;
    system_pkg::reg_data_t out0;
    system_pkg::reg_data_t out1;
    system_pkg::reg_data_t rdata;
    start_errors = error_count;
    for (int n = 0; n < 4; n++) begin
      out0 = $urandom();
      out1 = $urandom();
      reg_write(`REG_GPIO0_OUT, out0);
      reg_write(`REG_GPIO1_OUT, out1);
      reg_read(`REG_GPIO0_IN, rdata);
      check_value(64'(rdata[31:`GPIO_PIN_COUNT]), 64'(out0[31:`GPIO_PIN_COUNT]),
                  "GPIO0_IN loopback bits");
      reg_read(`REG_GPIO1_IN, rdata);
      check_value(64'(rdata), 64'(out1), "GPIO1_IN loopback");
    end
    record_result("gpio_loopback", start_errors);
  endtask

  task automatic video_timing();
    int   start_errors;
    int   de_len;
    int   hs_len;
    int   vs_len;
    int   lines;
    int   frames;
    int   last_rise;
    logic prev_de;
    logic prev_hs;
    logic prev_vs;
    bit   seen;
    start_errors = error_count;
    reg_write(`REG_VIDEO_CTRL, 32'h0000_0001);
    wait_vsync_rise(seen);
    if (seen) begin
      de_len    = 0;
      hs_len    = 0;
      vs_len    = 1;
      lines     = 0;
      frames    = 0;
      last_rise = 0;
      prev_de   = hdmi_data_e;
      prev_hs   = hdmi_hsync;
      prev_vs   = 1'b1;
      // Two frames from one vsync rise up to and including the next two
      for (int i = 1; i <= 2 * FRAME_CYCLES; i++) begin
        @(posedge sys_clk);
        #1;
        check_value(64'(hdmi_data_e & (hdmi_hsync | hdmi_vsync)), 64'd0, "Data enable in sync");
        if (hdmi_data_e) de_len = de_len + 1;
        if (hdmi_hsync) hs_len = hs_len + 1;
        if (hdmi_vsync) vs_len = vs_len + 1;
        if (!hdmi_data_e && prev_de) begin
          check_value(64'(de_len), 64'(`H_ACTIVE_LEN), "Data enable cycles per line");
          de_len = 0;
          lines  = lines + 1;
        end
        if (!hdmi_hsync && prev_hs) begin
          check_value(64'(hs_len), 64'(`H_SYNC_LEN), "Hsync length");
          hs_len = 0;
        end
        if (!hdmi_vsync && prev_vs) begin
          check_value(64'(vs_len), 64'(`V_SYNC_LEN * LINE_CYCLES), "Vsync length");
          vs_len = 0;
        end
        if (hdmi_vsync && !prev_vs) begin
          check_value(64'(i - last_rise), 64'(FRAME_CYCLES), "Frame period");
          check_value(64'(lines), 64'(`V_ACTIVE_LEN), "Active lines per frame");
          lines     = 0;
          frames    = frames + 1;
          last_rise = i;
        end
        prev_de = hdmi_data_e;
        prev_hs = hdmi_hsync;
        prev_vs = hdmi_vsync;
      end
      check_value(64'(frames), 64'd2, "Frames seen");
    end
    record_result("video_timing", start_errors);
  endtask

  // Scans one frame and checks every sample against bars or a solid colour
  task automatic frame_pixels(input bit solid, input system_pkg::pixel_t color);
    int pix;
    int active;
    bit seen;
    wait_vsync_rise(seen);
    pix    = 0;
    active = 0;
    for (int i = 0; i < FRAME_CYCLES; i++) begin
      @(posedge sys_clk);
      #1;
      if (hdmi_data_e) begin
        check_value(64'(hdmi_data), 64'(solid ? color : bar_sample(pix)),
                    $sformatf("Active pixel %0d", pix));
        pix    = pix + 1;
        active = active + 1;
      end else begin
        check_value(64'(hdmi_data), 64'd0, "Data in blanking");
        pix = 0;
      end
    end
    check_value(64'(active), 64'(`H_ACTIVE_LEN * `V_ACTIVE_LEN), "Active pixels per frame");
  endtask

  task automatic video_pixels();
    int                 start_errors;
    system_pkg::pixel_t color;
    start_errors = error_count;
    frame_pixels(1'b0, 16'h0000);
    color = 16'($urandom());
    reg_write(`REG_VIDEO_CTRL, {color, 14'd0, 2'b11});
    frame_pixels(1'b1, color);
    record_result("video_pixels", start_errors);
  endtask

  task automatic video_disable();
    int start_errors;
    int waited;
    start_errors = error_count;
    reg_write(`REG_VIDEO_CTRL, 32'd0);
    waited = 0;
    while ((hdmi_hsync || hdmi_vsync || hdmi_data_e || hdmi_data != 16'd0) && waited < 5) begin
      @(posedge sys_clk);
      #1;
      waited = waited + 1;
    end
    if (hdmi_hsync || hdmi_vsync || hdmi_data_e || hdmi_data != 16'd0) begin
      $display("HDMI outputs did not go idle within %0d cycles of the disable", waited);
      error_count = error_count + 1;
    end
    for (int i = 0; i < FRAME_CYCLES; i++) begin
      @(posedge sys_clk);
      #1;
      check_value(64'({hdmi_hsync, hdmi_vsync, hdmi_data_e, hdmi_data}), 64'd0,
                  "HDMI outputs while disabled");
    end
    record_result("video_disable", start_errors);
  endtask

  // ******************************
  // Main sequence
  // ******************************

  initial begin
    sys_clk       = 1'b0;
    rst_n         = 1'b0;
    reg_wr        = 1'b0;
    reg_rd        = 1'b0;
    reg_addr      = '0;
    reg_wdata     = '0;
    pin_drive_en  = 1'b0;
    pin_drive_val = '0;
    error_count   = 0;
    pass_count    = 0;
    fail_count    = 0;
    cycle_count   = 0;
    void'($urandom(32'hfe2d_4f53));
    repeat (10) @(posedge sys_clk);
    #1;
    rst_n = 1'b1;
    reset_and_id();
    gpio_pins();
    gpio_loopback();
    video_timing();
    video_pixels();
    video_disable();
    $display("Summary: passed %0d, failed %0d, errors %0d", pass_count, fail_count, error_count);
    if (error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+design
design/system_pkg.sv
design/cpu_reg_if.sv
design/gpio_bank.sv
design/hdmi_timing_gen.sv
design/hdmi_pattern_out.sv
design/system_top.sv
verification/system_top_sva.sv
verification/system_top_tb.sv

// ==== Makefile ====
# Verilator build and run of the system_top testbench

VERILATOR ?= verilator
TOP       ?= system_top_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard design/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -qx 'test passed' $(LOG); then \
		echo "Simulation passed, log in $(LOG)"; \
	else \
		echo "Simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
